//--- common/sbox_params.svh
`ifndef SBOX_PARAMS_SVH
`define SBOX_PARAMS_SVH

// Byte lanes in one 32-bit word
`define SBOX_LANES 4

// Cycles through one composite-field inversion lane
`define SBOX_INV_LATENCY 3

// Input register, inversion lane and output register
`define SBOX_TOTAL_LATENCY 5

`endif

//--- common/sbox_pkg.sv
`default_nettype none

package sbox_pkg;

    typedef logic [3:0] gf_nibble_t;   // GF(2^4) element

    typedef struct packed {
        gf_nibble_t high;
        gf_nibble_t low;
    } gf_pair_t;

    // Same byte seen as GF(2^8) or as a GF((2^4)^2) pair
    typedef union packed {
        logic [7:0] flat;
        gf_pair_t   pair;
    } gf_byte_t;

    typedef gf_byte_t [3:0] sbox_word_t;   // Lane 0 in the low byte

    typedef struct packed {
        logic valid;
        logic inverse;   // Set for the inverse S-box
    } sbox_side_t;

    typedef struct packed {
        sbox_side_t side;
        sbox_word_t word;
    } sbox_beat_t;

    // x^2 followed by multiplication with lambda
    function automatic gf_nibble_t gf16_square_scale(input gf_nibble_t q);
        gf16_square_scale = {q[2] ^ q[1] ^ q[0], q[3] ^ q[0], q[3], q[3] ^ q[2]};
    endfunction

    function automatic logic [7:0] aes_affine(input logic [7:0] a);
        aes_affine = a ^ {a[6:0], a[7]} ^ {a[5:0], a[7:6]} ^ {a[4:0], a[7:5]}
                   ^ {a[3:0], a[7:4]} ^ 8'h63;
    endfunction

    // Rotations by 1, 3 and 6
    function automatic logic [7:0] aes_affine_inv(input logic [7:0] a);
        aes_affine_inv = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
    endfunction

endpackage

`default_nettype wire

//--- multiplicative_inversion/byte_isomorphic_mapping.sv
`timescale 1ns/10ps
`default_nettype none

module byte_isomorphic_mapping #(
    parameter int INVERSE = 0
) (
    input  wire sbox_pkg::gf_byte_t i_q,
    output sbox_pkg::gf_byte_t o_delta
);

    logic [7:0] q;

    assign q = i_q.flat;

    generate
        if (INVERSE == 0) begin : gen_forward
            // GF(2^8) into GF((2^4)^2)
            assign o_delta.flat = {
                q[7] ^ q[5],
                q[7] ^ q[6] ^ q[4] ^ q[3] ^ q[2] ^ q[1],
                q[7] ^ q[5] ^ q[3] ^ q[2],
                q[7] ^ q[5] ^ q[3] ^ q[2] ^ q[1],
                q[7] ^ q[6] ^ q[2] ^ q[1],
                q[7] ^ q[4] ^ q[3] ^ q[2] ^ q[1],
                q[6] ^ q[4] ^ q[1],
                q[6] ^ q[1] ^ q[0]
            };
        end else begin : gen_inverse
            // Back into the AES polynomial basis
            assign o_delta.flat = {
                q[7] ^ q[6] ^ q[5] ^ q[1],
                q[6] ^ q[2],
                q[6] ^ q[5] ^ q[1],
                q[6] ^ q[5] ^ q[4] ^ q[2] ^ q[1],
                q[5] ^ q[4] ^ q[3] ^ q[2] ^ q[1],
                q[7] ^ q[4] ^ q[3] ^ q[2] ^ q[1],
                q[5] ^ q[4],
                q[6] ^ q[5] ^ q[4] ^ q[2] ^ q[0]
            };
        end
    endgenerate

endmodule

`default_nettype wire

//--- multiplicative_inversion/gf_2to4_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module gf_2to4_multiplier #(
    parameter int CREATE_OUTPUT_REG = 0
) (
    input  wire                  i_clock,
    input  wire sbox_pkg::gf_nibble_t i_x,
    input  wire sbox_pkg::gf_nibble_t i_y,
    output sbox_pkg::gf_nibble_t o_prod
);

    import sbox_pkg::*;

    gf_nibble_t product;

    // GF(2^2) product
    function automatic logic [1:0] gf4_mult(input logic [1:0] a, input logic [1:0] b);
        gf4_mult = {(a[1] & b[1]) ^ (a[0] & b[1]) ^ (a[1] & b[0]),
                    (a[1] & b[1]) ^ (a[0] & b[0])};
    endfunction

    // Multiply by phi = 2'b10
    function automatic logic [1:0] gf4_phi(input logic [1:0] a);
        gf4_phi = {a[1] ^ a[0], a[1]};
    endfunction

    assign product[3:2] = gf4_mult(i_x[3:2], i_y[3:2]) ^ gf4_mult(i_x[3:2], i_y[1:0])
                        ^ gf4_mult(i_x[1:0], i_y[3:2]);
    assign product[1:0] = gf4_phi(gf4_mult(i_x[3:2], i_y[3:2]))
                        ^ gf4_mult(i_x[1:0], i_y[1:0]);

    generate
        if (CREATE_OUTPUT_REG == 1) begin : gen_out_reg
            always_ff @(posedge i_clock) begin
                o_prod <= product;
            end
        end else begin : gen_out_comb
            assign o_prod = product;
        end
    endgenerate

endmodule

`default_nettype wire

//--- multiplicative_inversion/gf_2to4_multiplicative_inversion.sv
`timescale 1ns/10ps
`default_nettype none

module gf_2to4_multiplicative_inversion (
    input  wire sbox_pkg::gf_nibble_t i_q,
    output sbox_pkg::gf_nibble_t o_inv_q
);

    logic q3;
    logic q2;
    logic q1;
    logic q0;

    assign q3 = i_q[3];
    assign q2 = i_q[2];
    assign q1 = i_q[1];
    assign q0 = i_q[0];

    // Zero falls out as zero, no special case needed
    assign o_inv_q[3] = q3 ^ (q3 & q2 & q1) ^ (q3 & q0) ^ q2;

    assign o_inv_q[2] = (q3 & q2 & q1) ^ (q3 & q2 & q0) ^ (q3 & q0) ^ q2
                      ^ (q2 & q1);

    assign o_inv_q[1] = q3 ^ (q3 & q2 & q1) ^ (q3 & q1 & q0) ^ q2
                      ^ (q2 & q0) ^ q1;

    assign o_inv_q[0] = (q3 & q2 & q1) ^ (q3 & q2 & q0) ^ (q3 & q1)
                      ^ (q3 & q1 & q0) ^ (q3 & q0) ^ q2 ^ (q2 & q1)
                      ^ (q2 & q1 & q0) ^ q1 ^ q0;

endmodule

`default_nettype wire

//--- multiplicative_inversion/multiplicative_inversion.sv
`timescale 1ns/10ps
`default_nettype none

module multiplicative_inversion (
    input  wire                i_clock,
    input  wire                i_reset,
    input  wire sbox_pkg::gf_byte_t i_data,
    output sbox_pkg::gf_byte_t o_mult_inverse
);

    import sbox_pkg::*;

    gf_byte_t   delta;          // Input mapped into GF((2^4)^2)
    gf_nibble_t delta_hl;       // High plus low
    gf_nibble_t h_scaled;       // lambda * high^2
    gf_nibble_t hl_prod;        // (high + low) * low
    gf_nibble_t delta_h_reg;
    gf_nibble_t delta_hl_reg;
    gf_nibble_t h_scaled_reg;
    gf_nibble_t hl_prod_reg;
    gf_nibble_t norm;           // Value to invert in GF(2^4)
    gf_nibble_t inv_q;
    gf_nibble_t prod_high;
    gf_nibble_t prod_low;
    gf_byte_t   pair_out;
    gf_byte_t   inv_delta;

    byte_isomorphic_mapping #(
        .INVERSE (0)
    ) u_forward_mapping (
        .i_q     (i_data),
        .o_delta (delta)
    );

    assign delta_hl = delta.pair.high ^ delta.pair.low;
    assign h_scaled = gf16_square_scale(delta.pair.high);

    gf_2to4_multiplier #(
        .CREATE_OUTPUT_REG (0)
    ) u_gf_2to4_multiplier_hl (
        .i_clock (i_clock),
        .i_x     (delta_hl),
        .i_y     (delta.pair.low),
        .o_prod  (hl_prod)
    );

    // First pipe stage
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            delta_h_reg  <= '0;
            delta_hl_reg <= '0;
            h_scaled_reg <= '0;
            hl_prod_reg  <= '0;
        end else begin
            delta_h_reg  <= delta.pair.high;
            delta_hl_reg <= delta_hl;
            h_scaled_reg <= h_scaled;
            hl_prod_reg  <= hl_prod;
        end
    end

    assign norm = h_scaled_reg ^ hl_prod_reg;

    gf_2to4_multiplicative_inversion u_gf_2to4_multiplicative_inversion (
        .i_q     (norm),
        .o_inv_q (inv_q)
    );

    // Second pipe stage sits inside these two multipliers
    gf_2to4_multiplier #(
        .CREATE_OUTPUT_REG (1)
    ) u_gf_2to4_multiplier_high (
        .i_clock (i_clock),
        .i_x     (inv_q),
        .i_y     (delta_h_reg),
        .o_prod  (prod_high)
    );

    gf_2to4_multiplier #(
        .CREATE_OUTPUT_REG (1)
    ) u_gf_2to4_multiplier_low (
        .i_clock (i_clock),
        .i_x     (inv_q),
        .i_y     (delta_hl_reg),
        .o_prod  (prod_low)
    );

    assign pair_out.pair = '{high: prod_high, low: prod_low};

    byte_isomorphic_mapping #(
        .INVERSE (1)
    ) u_inverse_mapping (
        .i_q     (pair_out),
        .o_delta (inv_delta)
    );

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_mult_inverse <= '0;
        end else begin
            o_mult_inverse <= inv_delta;   // Third stage
        end
    end

endmodule

`default_nettype wire

//--- source/affine_input_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "sbox_params.svh"

module affine_input_stage (
    input  wire                  i_clock,
    input  wire                  i_reset,
    input  wire                  i_valid,
    input  wire                  i_inverse,
    input  wire sbox_pkg::sbox_word_t i_word,
    output sbox_pkg::sbox_beat_t o_beat
);

    import sbox_pkg::*;

    sbox_word_t pre_word;   // Word as it enters the inversion lanes

    // Inverse S-box undoes the affine step before inverting
    always_comb begin
        for (int lane = 0; lane < `SBOX_LANES; lane++) begin
            if (i_inverse) begin
                pre_word[lane].flat = aes_affine_inv(i_word[lane].flat);
            end else begin
                pre_word[lane].flat = i_word[lane].flat;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_beat.side.valid <= 1'b0;
        end else begin
            o_beat.side.valid <= i_valid;
        end
        o_beat.side.inverse <= i_inverse;   // Mode travels with its word
        o_beat.word         <= pre_word;
    end

endmodule

`default_nettype wire

//--- source/affine_output_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "sbox_params.svh"

module affine_output_stage (
    input  wire                  i_clock,
    input  wire                  i_reset,
    input  wire sbox_pkg::sbox_side_t i_side,
    input  wire sbox_pkg::sbox_word_t i_lanes,
    output logic                 o_valid,
    output sbox_pkg::sbox_word_t o_word
);

    import sbox_pkg::*;

    sbox_side_t [`SBOX_INV_LATENCY-1:0] side_pipe;   // Matches the lane latency
    sbox_side_t                         side_late;
    sbox_word_t                         post_word;

    assign side_late = side_pipe[`SBOX_INV_LATENCY-1];

    always_ff @(posedge i_clock) begin
        side_pipe <= {side_pipe[`SBOX_INV_LATENCY-2:0], i_side};
        if (i_reset) begin
            // Drop every word still in flight
            for (int stage = 0; stage < `SBOX_INV_LATENCY; stage++) begin
                side_pipe[stage].valid <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int lane = 0; lane < `SBOX_LANES; lane++) begin
            if (side_late.inverse) begin
                post_word[lane].flat = i_lanes[lane].flat;   // Inverse affine already done
            end else begin
                post_word[lane].flat = aes_affine(i_lanes[lane].flat);
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= side_late.valid;
        end
        o_word <= post_word;
    end

endmodule

`default_nettype wire

//--- source/sbox_word_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "sbox_params.svh"

module sbox_word_unit (
    input  wire                  i_clock,
    input  wire                  i_reset,
    input  wire                  i_valid,
    input  wire                  i_inverse,
    input  wire sbox_pkg::sbox_word_t i_word,
    output logic                 o_valid,
    output sbox_pkg::sbox_word_t o_word
);

    import sbox_pkg::*;

    sbox_beat_t      beat;          // Registered word and sideband
    wire sbox_word_t lane_result;   // Inverses, three cycles behind beat

    affine_input_stage u_affine_input_stage (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_inverse (i_inverse),
        .i_word    (i_word),
        .o_beat    (beat)
    );

    generate
        for (genvar lane = 0; lane < `SBOX_LANES; lane++) begin : gen_lane
            multiplicative_inversion u_multiplicative_inversion (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_data         (beat.word[lane]),
                .o_mult_inverse (lane_result[lane])
            );
        end
    endgenerate

    affine_output_stage u_affine_output_stage (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_side  (beat.side),
        .i_lanes (lane_result),
        .o_valid (o_valid),
        .o_word  (o_word)
    );

endmodule

`default_nettype wire

//--- testbench/sbox_word_unit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "sbox_params.svh"

module sbox_word_unit_asserts (
    input wire                       i_clock,
    input wire                       i_reset,
    input wire                       i_valid,
    input wire                       i_out_valid,
    input wire sbox_pkg::sbox_word_t i_out_word
);

    int cycles_since_reset = 0;   // Saturates once the pipeline is full again

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            cycles_since_reset <= 0;
        end else if (cycles_since_reset < 15) begin
            cycles_since_reset <= cycles_since_reset + 1;
        end
    end

    // Nothing leaves while the pipeline refills
    a_quiet_after_reset: assert property (@(posedge i_clock)
            !i_reset && cycles_since_reset < `SBOX_TOTAL_LATENCY |-> !i_out_valid)
        else $error("o_valid went high too soon after reset release");

    a_valid_follows: assert property (@(posedge i_clock)
            !i_reset && cycles_since_reset >= `SBOX_TOTAL_LATENCY
            |-> i_out_valid == $past(i_valid, `SBOX_TOTAL_LATENCY))
        else $error("o_valid does not follow i_valid by the pipeline latency");

    a_word_known: assert property (@(posedge i_clock)
            i_out_valid |-> !$isunknown(i_out_word))
        else $error("o_word has unknown bits while o_valid is high");

endmodule

bind sbox_word_unit sbox_word_unit_asserts u_sbox_word_unit_asserts (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_out_valid (o_valid),
    .i_out_word  (o_word)
);

`default_nettype wire

//--- testbench/sbox_word_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sbox_params.svh"

module sbox_word_unit_tb;

    import sbox_pkg::*;

    localparam int CYCLE_LIMIT = 1200;   // About twice the stimulus length

    logic        i_clock;
    logic        i_reset;
    logic        i_valid;
    logic        i_inverse;
    sbox_word_t  i_word;
    logic        o_valid;
    sbox_word_t  o_word;
    logic [7:0]  fwd_sbox [256];
    logic [7:0]  inv_sbox [256];
    logic [31:0] expected_words [$];   // Model results in issue order
    logic [31:0] expect_front = '0;
    logic        have_expected = 1'b0;
    integer      seed;
    int          cycle_count = 0;

    sbox_word_unit uut (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_inverse (i_inverse),
        .i_word    (i_word),
        .o_valid   (o_valid),
        .o_word    (o_word)
    );

    initial begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Shift and add, reducing by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf_multiply(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] shifted;
        acc = 8'h00;
        shifted = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ shifted;
            end
            shifted = {shifted[6:0], 1'b0} ^ (shifted[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    function automatic logic [7:0] find_inverse(input logic [7:0] a);
        logic [7:0] inv;
        inv = 8'h00;   // Zero keeps zero
        for (int c = 1; c < 256; c++) begin
            if (gf_multiply(a, 8'(c)) == 8'h01) begin
                inv = 8'(c);
            end
        end
        return inv;
    endfunction

    function automatic logic [7:0] forward_affine(input logic [7:0] a);
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = a[i] ^ a[(i + 4) % 8] ^ a[(i + 5) % 8] ^ a[(i + 6) % 8] ^ a[(i + 7) % 8];
        end
        return b ^ 8'h63;
    endfunction

    function automatic logic [7:0] inverse_affine(input logic [7:0] a);
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = a[(i + 2) % 8] ^ a[(i + 5) % 8] ^ a[(i + 7) % 8];
        end
        return b ^ 8'h05;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] word, input logic mode);
        logic [31:0] result;
        for (int lane = 0; lane < `SBOX_LANES; lane++) begin
            if (mode) begin
                result[8*lane +: 8] = inv_sbox[word[8*lane +: 8]];
            end else begin
                result[8*lane +: 8] = fwd_sbox[word[8*lane +: 8]];
            end
        end
        return result;
    endfunction

    task automatic build_tables();
        for (int x = 0; x < 256; x++) begin
            fwd_sbox[x] = forward_affine(find_inverse(8'(x)));
            inv_sbox[x] = find_inverse(inverse_affine(8'(x)));
        end
    endtask

    task automatic send_word(input logic [31:0] word, input logic mode);
        @(negedge i_clock);
        i_valid   = 1'b1;
        i_inverse = mode;
        i_word    = word;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge i_clock);
            i_valid = 1'b0;
        end
    endtask

    // Scoreboard follows what the DUT samples on each edge
    always @(posedge i_clock) begin
        if (o_valid && expected_words.size() != 0) begin
            void'(expected_words.pop_front());
        end
        if (i_reset) begin
            expected_words.delete();   // Words in flight are dropped
        end else if (i_valid) begin
            expected_words.push_back(expected_word(i_word, i_inverse));
        end
        have_expected <= expected_words.size() != 0;
        if (expected_words.size() != 0) begin
            expect_front <= expected_words[0];
        end
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            abort_run("Run timed out before the tests completed");
        end
    end

    a_output_expected: assert property (@(posedge i_clock) disable iff (i_reset)
            o_valid |-> have_expected)
        else abort_run("o_valid went high with no word waiting for it");

    a_word_matches: assert property (@(posedge i_clock) disable iff (i_reset)
            o_valid && have_expected |-> o_word == expect_front)
        else abort_run($sformatf("Mismatch at %0t: o_word expected %h, got %h",
                                 $time, $sampled(expect_front), $sampled(o_word)));

    initial begin
        int          draw;
        int          gap_bits;
        logic [31:0] word;
        seed      = 32'hfc9c;
        i_reset   = 1'b1;
        i_valid   = 1'b0;
        i_inverse = 1'b0;
        i_word    = '0;
        build_tables();
        repeat (8) @(negedge i_clock);
        i_reset = 1'b0;

        // Every byte value, forward pass then inverse pass
        for (int mode = 0; mode < 2; mode++) begin
            for (int w = 0; w < 64; w++) begin
                for (int lane = 0; lane < `SBOX_LANES; lane++) begin
                    word[8*lane +: 8] = 8'(4 * w + lane);
                end
                send_word(word, mode[0]);
            end
        end

        // Forward results back through inverse mode
        for (int w = 0; w < 64; w++) begin
            for (int lane = 0; lane < `SBOX_LANES; lane++) begin
                word[8*lane +: 8] = fwd_sbox[4 * w + lane];
            end
            send_word(word, 1'b1);
        end

        for (int n = 0; n < 200; n++) begin
            draw     = $random(seed);
            gap_bits = $random(seed);
            send_word(draw, gap_bits[5]);   // Modes mix inside the pipeline
            if (gap_bits[1]) begin
                idle_cycles(int'(gap_bits[0]) + 1);
            end
        end

        // Reset hits while words are in flight
        for (int n = 0; n < 6; n++) begin
            draw = $random(seed);
            send_word(draw, n[0]);
        end
        @(negedge i_clock);
        i_valid = 1'b0;
        i_reset = 1'b1;
        repeat (2) @(negedge i_clock);
        i_reset = 1'b0;
        idle_cycles(`SBOX_TOTAL_LATENCY + 1);
        for (int n = 0; n < 8; n++) begin
            draw = $random(seed);
            send_word(draw, n[1]);
        end
        idle_cycles(`SBOX_TOTAL_LATENCY + 2);

        if (expected_words.size() != 0) begin
            abort_run("Expected output words never appeared");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/sbox_pkg.sv
multiplicative_inversion/byte_isomorphic_mapping.sv
multiplicative_inversion/gf_2to4_multiplier.sv
multiplicative_inversion/gf_2to4_multiplicative_inversion.sv
multiplicative_inversion/multiplicative_inversion.sv
source/affine_input_stage.sv
source/affine_output_stage.sv
source/sbox_word_unit.sv
testbench/sbox_word_unit_asserts.sv
testbench/sbox_word_unit_tb.sv

//--- Makefile
TOP := sbox_word_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --timescale 1ns/10ps --top-module $(TOP) -f build.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
